/* sim.f */
hps_pkg.sv
umuldiv.sv
hps_cmd_port.sv
video_cfg_regs.sv
ar_window_calc.sv
sync_polarity_fix.sv
csync_gen.sv
hps_video_ctrl.sv
tb_hps_video_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the HPS video control testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_hps_video_ctrl -f sim.f \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_hps_video_ctrl > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
exit 0

/* tb_hps_video_ctrl.sv */
////////////////////////////////////////////////////////////
// HPS video control testbench
// Host command sequences, window results, sync
// normalization, composite sync and the vsync hold
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_hps_video_ctrl;

	localparam int TIMEOUT = 20000;

	logic                      clk_sys = 1'b0;
	logic                      resetd;
	logic                      i_io_clk;
	logic                      i_io_sel;
	logic [hps_pkg::IO_W-1:0]  i_io_din;
	logic [hps_pkg::DIM_W-1:0] i_arx;
	logic [hps_pkg::DIM_W-1:0] i_ary;
	logic                      i_hs;
	logic                      i_vs;
	logic                      o_io_ack;
	logic [hps_pkg::IO_W-1:0]  o_io_dout;
	logic [hps_pkg::VOL_W-1:0] o_vol_att;
	logic [hps_pkg::IO_W-1:0]  o_led;
	hps_pkg::window_t          o_window;
	logic                      o_hs;
	logic                      o_vs;
	logic                      o_cs;

	logic [hps_pkg::IO_W-1:0]  words [8];
	logic [hps_pkg::VOL_W-1:0] vol;
	logic [hps_pkg::IO_W-1:0]  led;
	logic                      hold_on;
	logic                      norm_chk;
	logic                      cs_chk;
	logic                      hs_d = 1'b1;
	integer                    seed;
	int                        cycles;
	int                        val_errs = 0;
	int                        assert_errs = 0;

	hps_video_ctrl u_hps_video_ctrl (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_sel  (i_io_sel),
		.i_io_din  (i_io_din),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.i_hs      (i_hs),
		.i_vs      (i_vs),
		.o_io_ack  (o_io_ack),
		.o_io_dout (o_io_dout),
		.o_vol_att (o_vol_att),
		.o_led     (o_led),
		.o_window  (o_window),
		.o_hs      (o_hs),
		.o_vs      (o_vs),
		.o_cs      (o_cs)
	);

	always #10 clk_sys = ~clk_sys;

	// Raw hsync one clock late
	always @(posedge clk_sys) hs_d <= i_hs;

	////////////////////////////////////////////////////////////
	// Checking assertions

	a_ack_rise: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_io_clk) |-> ##2 o_io_ack)
		else begin
			assert_errs++;
			$display("ERROR %0t: o_io_ack not high two cycles after i_io_clk rose", $time);
		end

	a_hold_rel: assert property (@(posedge clk_sys) disable iff (resetd)
		hold_on && $rose(o_vs) |-> ##3 !o_io_ack)
		else begin
			assert_errs++;
			$display("ERROR %0t: o_io_ack still high after the vsync edge", $time);
		end

	a_hold_keep: assert property (@(posedge clk_sys) disable iff (resetd)
		hold_on && $fell(o_io_ack) |-> $past(o_vs, 3) && !$past(o_vs, 4))
		else begin
			assert_errs++;
			$display("ERROR %0t: o_io_ack dropped before the vsync edge", $time);
		end

	a_vs_norm: assert property (@(posedge clk_sys) disable iff (resetd)
		norm_chk |-> o_vs == !i_vs)
		else begin
			assert_errs++;
			$display("FAIL %0t o_vs got %b exp %b", $time, $sampled(o_vs), !$sampled(i_vs));
		end

	a_hs_norm: assert property (@(posedge clk_sys) disable iff (resetd)
		norm_chk |-> o_hs == !hs_d)
		else begin
			assert_errs++;
			$display("FAIL %0t o_hs got %b exp %b", $time, $sampled(o_hs), !$sampled(hs_d));
		end

	a_cs_sel: assert property (@(posedge clk_sys) disable iff (resetd)
		cs_chk |-> o_hs == o_cs)
		else begin
			assert_errs++;
			$display("FAIL %0t o_hs got %b exp %b", $time, $sampled(o_hs), $sampled(o_cs));
		end

	// Outside vsync the composite output is plain hsync
	a_cs_line: assert property (@(posedge clk_sys) disable iff (resetd)
		cs_chk && !o_vs && !$past(o_vs) |-> o_cs == !hs_d)
		else begin
			assert_errs++;
			$display("FAIL %0t o_cs got %b exp %b", $time, $sampled(o_cs), !$sampled(hs_d));
		end

	////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic step;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		if (got != exp) begin
			val_errs++;
			$display("FAIL %0t %s got %0d exp %0d", $time, name, got, exp);
		end
	endtask

	task automatic wait_ack(input logic level);
		do
			step();
		while (o_io_ack != level);
	endtask

	task automatic send_word(input logic [hps_pkg::IO_W-1:0] w, input logic hold);
		i_io_din = w;
		i_io_clk = 1'b1;
		wait_ack(1'b1);
		i_io_clk = 1'b0;
		hold_on  = hold;
		wait_ack(1'b0);
		step();
		hold_on = 1'b0;
	endtask

	// Opcode word, then words[0] to words[n-1]
	task automatic send_cmd(input hps_pkg::hps_cmd_e op, input int n);
		i_io_sel = 1'b1;
		step();
		send_word(16'(op), op == hps_pkg::CMD_VSWAIT);
		if (op == hps_pkg::CMD_VMODE)
			check_val("o_io_dout", int'(o_io_dout), 3);
		for (int i = 0; i < n; i++)
			send_word(words[i], 1'b0);
		i_io_sel = 1'b0;
		step();
	endtask

	task automatic send_one(input hps_pkg::hps_cmd_e op, input logic [hps_pkg::IO_W-1:0] w);
		words[0] = w;
		send_cmd(op, 1);
	endtask

	task automatic set_mode(input int w, input int h);
		words[0] = 16'(w);
		words[1] = 16'd16;
		words[2] = 16'd96;
		words[3] = 16'd48;
		words[4] = 16'(h);
		words[5] = 16'd10;
		words[6] = 16'd2;
		words[7] = 16'd33;
		send_cmd(hps_pkg::CMD_VMODE, 8);
	endtask

	task automatic check_window(input int hmin, input int hmax, input int vmin, input int vmax);
		repeat (200) step();
		check_val("o_window.hmin", int'(o_window.hmin), hmin);
		check_val("o_window.hmax", int'(o_window.hmax), hmax);
		check_val("o_window.vmin", int'(o_window.vmin), vmin);
		check_val("o_window.vmax", int'(o_window.vmax), vmax);
	endtask

	// Active-low hsync and vsync, vsync pulse on the first lines
	task automatic sync_gen(input int line_len, input int hs_len, input int lines,
		input int vs_lines, input int frames);
		for (int f = 0; f < frames; f++)
			for (int l = 0; l < lines; l++)
				for (int c = 0; c < line_len; c++) begin
					i_vs = (l >= vs_lines);
					i_hs = (c >= hs_len);
					step();
				end
	endtask

	task automatic wait_vs_end;
		while (!o_vs)
			step();
		while (o_vs)
			step();
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed     = 13060;
		resetd   = 1'b1;
		i_io_clk = 1'b0;
		i_io_sel = 1'b0;
		i_io_din = '0;
		i_arx    = '0;
		i_ary    = '0;
		i_hs     = 1'b1;
		i_vs     = 1'b1;
		hold_on  = 1'b0;
		norm_chk = 1'b0;
		cs_chk   = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		step();

		check_val("o_vol_att", int'(o_vol_att), (1 << hps_pkg::VOL_W) - 1);
		vol = hps_pkg::VOL_W'($random(seed));
		led = hps_pkg::IO_W'($random(seed));
		send_one(hps_pkg::CMD_VOL, 16'(vol));
		send_one(hps_pkg::CMD_LED, led);
		check_val("o_vol_att", int'(o_vol_att), int'(vol));
		check_val("o_led", int'(o_led), int'(led));

		// No aspect ratio, then a vertical limit
		set_mode(640, 480);
		check_window(0, 639, 0, 479);
		send_one(hps_pkg::CMD_VSET, 16'd400);
		check_window(0, 639, 40, 439);

		// 4:3 inside 800x480, then freescale
		send_one(hps_pkg::CMD_VSET, 16'd0);
		i_arx = 12'd4;
		i_ary = 12'd3;
		set_mode(800, 480);
		check_window(80, 719, 0, 479);
		send_one(hps_pkg::CMD_HSET, 16'h8000);
		check_window(0, 799, 0, 479);

		fork
			sync_gen(60, 6, 10, 2, 10);
		join_none
		repeat (1500) step();
		norm_chk = 1'b1;
		repeat (700) step();
		norm_chk = 1'b0;
		send_one(hps_pkg::CMD_CFG, 16'h0008);
		cs_chk = 1'b1;
		repeat (700) step();
		cs_chk = 1'b0;

		// Hold starts right after a vsync pulse
		wait_vs_end();
		send_cmd(hps_pkg::CMD_VSWAIT, 0);

		$display("Checks done: %0d value errors, %0d assertion errors", val_errs, assert_errs);
		if (val_errs == 0 && assert_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
		$display("Checks done: %0d value errors, %0d assertion errors", val_errs, assert_errs);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* hps_video_ctrl.sv */
////////////////////////////////////////////////////////////
// HPS video control top
// Host command port, register bank, window calculator and
// sync conditioning on the system clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hps_video_ctrl (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  logic                      i_io_clk,
	input  logic                      i_io_sel,
	input  logic [hps_pkg::IO_W-1:0]  i_io_din,
	input  logic [hps_pkg::DIM_W-1:0] i_arx,
	input  logic [hps_pkg::DIM_W-1:0] i_ary,
	input  logic                      i_hs,
	input  logic                      i_vs,
	output logic                      o_io_ack,
	output logic [hps_pkg::IO_W-1:0]  o_io_dout,
	output logic [hps_pkg::VOL_W-1:0] o_vol_att,
	output logic [hps_pkg::IO_W-1:0]  o_led,
	output hps_pkg::window_t          o_window,
	output logic                      o_hs,
	output logic                      o_vs,
	output logic                      o_cs
);

	hps_pkg::cmd_beat_t       beat;
	hps_pkg::video_timing_t   timing;
	hps_pkg::scale_ctrl_t     scale;
	logic [hps_pkg::IO_W-1:0] cfg;
	logic                     vs_wait;
	logic                     hs_fix;

	//////////////////////////////////////////////////////////////
	// Host side

	hps_cmd_port u_hps_cmd_port (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_sel  (i_io_sel),
		.i_io_din  (i_io_din),
		.i_vs_wait (vs_wait),
		.o_io_ack  (o_io_ack),
		.o_beat    (beat)
	);

	video_cfg_regs u_video_cfg_regs (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_beat    (beat),
		.i_io_sel  (i_io_sel),
		.i_vs_rise (o_vs),
		.o_timing  (timing),
		.o_scale   (scale),
		.o_cfg     (cfg),
		.o_vol_att (o_vol_att),
		.o_led     (o_led),
		.o_vs_wait (vs_wait),
		.o_io_dout (o_io_dout)
	);

	ar_window_calc u_ar_window_calc (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_timing (timing),
		.i_scale  (scale),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_window (o_window)
	);

	//////////////////////////////////////////////////////////////
	// Sync path

	sync_polarity_fix u_fix_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix u_fix_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

	// cfg bit 3 enables composite sync on the hsync output
	csync_gen u_csync_gen (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hs       (hs_fix),
		.i_vs       (o_vs),
		.i_csync_en (cfg[3]),
		.o_hs_out   (o_hs),
		.o_cs       (o_cs)
	);

endmodule

/* csync_gen.sv */
////////////////////////////////////////////////////////////
// Composite sync
// Hsync shifted by one period and XORed with vsync during
// the vertical pulse, plus hsync output select
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync_en,
	output logic o_hs_out,
	output logic o_cs
);

	logic                           prev_hs, cs_hs, cs_vs;
	logic [hps_pkg::SYNC_CNT_W-1:0] h_cnt, line_len, hs_len;

	assign o_cs     = cs_hs ^ cs_vs;
	assign o_hs_out = i_csync_en ? o_cs : prev_hs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			h_cnt   <= h_cnt + 1'b1;
			prev_hs <= i_hs;
			if (prev_hs ^ i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			if (!i_vs)
				cs_hs <= i_hs;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;

			cs_vs <= i_vs;
		end
	end

endmodule

/* sync_polarity_fix.sv */
////////////////////////////////////////////////////////////
// Sync polarity normalization
// Flips a sync so its shorter phase is the high pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                           s1, s2, pol;
	logic [hps_pkg::SYNC_CNT_W-1:0] cnt, hi_len, lo_len;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			pol    <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (~s2 & s1)
				lo_len <= cnt;
			if (s2 & ~s1)
				hi_len <= cnt;
			// Run length, saturating on a stuck input
			if (s2 != s1)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
			pol <= hi_len > lo_len;
		end
	end

endmodule

/* ar_window_calc.sv */
////////////////////////////////////////////////////////////
// Aspect-ratio output window
// Loops over target size, aspect scaling and centring of
// the video inside the output mode
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ar_window_calc (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  hps_pkg::video_timing_t    i_timing,
	input  hps_pkg::scale_ctrl_t      i_scale,
	input  logic [hps_pkg::DIM_W-1:0] i_arx,
	input  logic [hps_pkg::DIM_W-1:0] i_ary,
	output hps_pkg::window_t          o_window
);

	hps_pkg::ar_state_e        state;
	logic [hps_pkg::DIM_W-1:0] tgt_w, tgt_h;
	logic [hps_pkg::DIM_W-1:0] arx_q, ary_q;
	logic [hps_pkg::DIM_W-1:0] wcalc, hcalc, videow, videoh;
	logic [hps_pkg::DIM_W-1:0] hmin, vmin;
	logic                      md_start, md_busy;
	logic [hps_pkg::DIM_W-1:0] md_mul1, md_mul2, md_div, md_res;

	umuldiv u_umuldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Scale limits apply only when set and smaller than the mode
	always_comb begin
		tgt_h = (i_scale.vset != '0 && i_scale.vset < i_timing.height) ?
			i_scale.vset : i_timing.height;
		tgt_w = (i_scale.hset != '0 && i_scale.hset < i_timing.width) ?
			i_scale.hset : i_timing.width;
	end

	assign hmin = (i_timing.width - videow) >> 1;
	assign vmin = (i_timing.height - videoh) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= hps_pkg::IDLE;
			md_start <= 1'b0;
			o_window <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				hps_pkg::IDLE: begin
					arx_q <= i_arx;
					ary_q <= i_ary;
					if (i_scale.freescale || i_arx == '0 || i_ary == '0) begin
						wcalc <= tgt_w;
						hcalc <= tgt_h;
						state <= hps_pkg::CLAMP;
					end else begin
						state <= hps_pkg::MUL_W;
					end
				end
				hps_pkg::MUL_W: begin
					md_mul1  <= tgt_h;
					md_mul2  <= arx_q;
					md_div   <= ary_q;
					md_start <= 1'b1;
					state    <= hps_pkg::WAIT_W;
				end
				hps_pkg::WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= hps_pkg::MUL_H;
					end
				end
				hps_pkg::MUL_H: begin
					md_mul1  <= tgt_w;
					md_mul2  <= ary_q;
					md_div   <= arx_q;
					md_start <= 1'b1;
					state    <= hps_pkg::WAIT_H;
				end
				hps_pkg::WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= hps_pkg::CLAMP;
					end
				end
				hps_pkg::CLAMP: begin
					videow <= (wcalc > tgt_w) ? tgt_w : wcalc;
					videoh <= (hcalc > tgt_h) ? tgt_h : hcalc;
					state  <= hps_pkg::CENTRE;
				end
				default: begin
					o_window.hmin <= hmin;
					o_window.hmax <= hmin + videow - hps_pkg::DIM_W'(1);
					o_window.vmin <= vmin;
					o_window.vmax <= vmin + videoh - hps_pkg::DIM_W'(1);
					state         <= hps_pkg::IDLE;
				end
			endcase
		end
	end

	a_div_nonzero: assert property (@(posedge clk_sys) disable iff (resetd)
		md_start |-> md_div != '0);

endmodule

/* video_cfg_regs.sv */
////////////////////////////////////////////////////////////
// Command register bank
// Decodes host beats into config, mode timing, LED, volume
// and scale registers; drives reply word and vsync wait
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module video_cfg_regs (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  hps_pkg::cmd_beat_t        i_beat,
	input  logic                      i_io_sel,
	input  logic                      i_vs_rise,
	output hps_pkg::video_timing_t    o_timing,
	output hps_pkg::scale_ctrl_t      o_scale,
	output logic [hps_pkg::IO_W-1:0]  o_cfg,
	output logic [hps_pkg::VOL_W-1:0] o_vol_att,
	output logic [hps_pkg::IO_W-1:0]  o_led,
	output logic                      o_vs_wait,
	output logic [hps_pkg::IO_W-1:0]  o_io_dout
);

	logic                      vs_q;
	logic                      vs_rise;
	logic                      first_word;
	logic [hps_pkg::DIM_W-1:0] beat_dim;

	// i_vs_rise carries the normalized vsync level, edge found here
	assign vs_rise    = i_vs_rise & ~vs_q;
	assign first_word = (i_beat.idx == 4'd0);
	assign beat_dim   = i_beat.data[hps_pkg::DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			vs_q      <= 1'b0;
			o_timing  <= '0;
			o_scale   <= '0;
			o_cfg     <= '0;
			o_vol_att <= hps_pkg::VOL_RESET;
			o_led     <= '0;
			o_vs_wait <= 1'b0;
			o_io_dout <= '0;
		end else begin
			vs_q <= i_vs_rise;
			if (vs_rise)
				o_vs_wait <= 1'b0;

			if (!i_io_sel) begin
				o_io_dout <= '0;
			end else if (i_beat.valid) begin
				o_io_dout <= '0;
				if (i_beat.is_cmd) begin
					if (i_beat.cmd == hps_pkg::CMD_VMODE)
						o_io_dout <= hps_pkg::IO_W'(3);
					if (i_beat.cmd == hps_pkg::CMD_VSWAIT)
						o_vs_wait <= 1'b1;
				end else begin
					case (i_beat.cmd)
						hps_pkg::CMD_CFG: if (first_word) o_cfg <= i_beat.data;
						hps_pkg::CMD_LED: if (first_word) o_led <= i_beat.data;
						hps_pkg::CMD_VOL: begin
							if (first_word)
								o_vol_att <= i_beat.data[hps_pkg::VOL_W-1:0];
						end
						hps_pkg::CMD_VSET: if (first_word) o_scale.vset <= beat_dim;
						hps_pkg::CMD_HSET: begin
							if (first_word) begin
								o_scale.freescale <= i_beat.data[15];
								o_scale.hset      <= beat_dim;
							end
						end
						hps_pkg::CMD_VMODE: begin
							if (i_beat.idx < 4'(hps_pkg::VMODE_WORDS)) begin
								case (i_beat.idx[2:0])
									3'd0: o_timing.width  <= beat_dim;
									3'd1: o_timing.hfp    <= beat_dim;
									3'd2: o_timing.hs     <= beat_dim;
									3'd3: o_timing.hbp    <= beat_dim;
									3'd4: o_timing.height <= beat_dim;
									3'd5: o_timing.vfp    <= beat_dim;
									3'd6: o_timing.vs     <= beat_dim;
									default: o_timing.vbp <= beat_dim;
								endcase
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// Wait is only ever requested by an opcode inside a selected command
	a_vs_wait_sel: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_vs_wait) |-> $past(i_io_sel));

endmodule

/* hps_cmd_port.sv */
////////////////////////////////////////////////////////////
// Host word port
// Strobe/ack handshake with vsync hold, frames host words
// into opcode and data beats
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hps_cmd_port (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     i_io_clk,
	input  logic                     i_io_sel,
	input  logic [hps_pkg::IO_W-1:0] i_io_din,
	input  logic                     i_vs_wait,
	output logic                     o_io_ack,
	output hps_pkg::cmd_beat_t       o_beat
);

	logic              ack_req;
	logic              strobe;
	logic              has_cmd;
	hps_pkg::hps_cmd_e cmd_q;
	logic [3:0]        idx_q;

	assign strobe = i_io_clk & ~ack_req;

	// Falling io_clk is held off while waiting for vsync
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			ack_req  <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			if (~i_vs_wait | strobe)
				ack_req <= i_io_clk;
			o_io_ack <= ack_req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd_q   <= hps_pkg::CMD_CFG;
			idx_q   <= '0;
		end else if (~i_io_sel) begin
			has_cmd <= 1'b0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd_q   <= hps_pkg::hps_cmd_e'(i_io_din[7:0]);
				idx_q   <= '0;
			end else if (idx_q != 4'hf) begin
				idx_q <= idx_q + 4'd1;
			end
		end
	end

	always_comb begin
		o_beat.valid  = strobe & i_io_sel;
		o_beat.is_cmd = ~has_cmd;
		o_beat.cmd    = has_cmd ? cmd_q : hps_pkg::hps_cmd_e'(i_io_din[7:0]);
		o_beat.idx    = idx_q;
		o_beat.data   = i_io_din;
	end

endmodule

/* umuldiv.sv */
////////////////////////////////////////////////////////////
// Sequential multiply-then-divide
// 24-bit product, then 24 restoring division steps
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module umuldiv (
	input  logic                      clk_sys,
	input  logic                      resetd,
	input  logic                      i_start,
	input  logic [hps_pkg::DIM_W-1:0] i_mul1,
	input  logic [hps_pkg::DIM_W-1:0] i_mul2,
	input  logic [hps_pkg::DIM_W-1:0] i_div,
	output logic                      o_busy,
	output logic [hps_pkg::DIM_W-1:0] o_result
);

	logic [hps_pkg::DIM_W-1:0]   mul1_q, mul2_q, div_q, rem;
	logic [2*hps_pkg::DIM_W-1:0] quo;
	logic [hps_pkg::DIM_W:0]     rem_sh;
	logic [hps_pkg::DIM_W+1:0]   diff;
	logic [4:0]                  cnt;

	assign rem_sh   = {rem, quo[2*hps_pkg::DIM_W-1]};
	assign diff     = {1'b0, rem_sh} - {2'b00, div_q};
	assign o_result = quo[hps_pkg::DIM_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			cnt    <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			cnt    <= '0;
			mul1_q <= i_mul1;
			mul2_q <= i_mul2;
			div_q  <= i_div;
		end else if (o_busy) begin
			cnt <= cnt + 5'd1;
			if (cnt == 5'd0) begin
				quo <= mul1_q * mul2_q;
				rem <= '0;
			end else begin
				// Keep the difference when there was no borrow
				if (!diff[hps_pkg::DIM_W+1])
					rem <= diff[hps_pkg::DIM_W-1:0];
				else
					rem <= rem_sh[hps_pkg::DIM_W-1:0];
				quo <= {quo[2*hps_pkg::DIM_W-2:0], ~diff[hps_pkg::DIM_W+1]};
				if (cnt == 5'd24)
					o_busy <= 1'b0;
			end
		end
	end

endmodule

/* hps_pkg.sv */
////////////////////////////////////////////////////////////
// HPS video control shared definitions
// Widths, host opcodes, calculator states and the packed
// structs passed between the command and scaler blocks
////////////////////////////////////////////////////////////

package hps_pkg;

	localparam int DIM_W       = 12;
	localparam int IO_W        = 16;
	localparam int VOL_W       = 5;
	localparam int VMODE_WORDS = 8;
	localparam int SYNC_CNT_W  = 16;

	// Fully muted
	localparam logic [VOL_W-1:0] VOL_RESET = '1;

	typedef enum logic [7:0] {
		CMD_CFG    = 8'h01,
		CMD_VMODE  = 8'h20,
		CMD_LED    = 8'h25,
		CMD_VOL    = 8'h26,
		CMD_VSET   = 8'h27,
		CMD_VSWAIT = 8'h30,
		CMD_HSET   = 8'h37
	} hps_cmd_e;

	typedef enum logic [2:0] {
		IDLE,
		MUL_W,
		WAIT_W,
		MUL_H,
		WAIT_H,
		CLAMP,
		CENTRE
	} ar_state_e;

	typedef struct packed {
		logic            valid;
		logic            is_cmd;
		hps_cmd_e        cmd;
		logic [3:0]      idx;
		logic [IO_W-1:0] data;
	} cmd_beat_t;

	typedef struct packed {
		logic [DIM_W-1:0] width;
		logic [DIM_W-1:0] hfp;
		logic [DIM_W-1:0] hs;
		logic [DIM_W-1:0] hbp;
		logic [DIM_W-1:0] height;
		logic [DIM_W-1:0] vfp;
		logic [DIM_W-1:0] vs;
		logic [DIM_W-1:0] vbp;
	} video_timing_t;

	typedef struct packed {
		logic [DIM_W-1:0] vset;
		logic [DIM_W-1:0] hset;
		logic             freescale;
	} scale_ctrl_t;

	typedef struct packed {
		logic [DIM_W-1:0] hmin;
		logic [DIM_W-1:0] hmax;
		logic [DIM_W-1:0] vmin;
		logic [DIM_W-1:0] vmax;
	} window_t;

endpackage
